// File: common/isa_pkg.sv
package isa_pkg;

  // Opcodes in instr[15:12]
  localparam logic [3:0] OP_ADD = 4'h0;
  localparam logic [3:0] OP_SUB = 4'h1;
  localparam logic [3:0] OP_XOR = 4'h2;
  localparam logic [3:0] OP_LW  = 4'h8;
  localparam logic [3:0] OP_SW  = 4'h9;
  localparam logic [3:0] OP_LLB = 4'hA;
  localparam logic [3:0] OP_LHB = 4'hB;
  localparam logic [3:0] OP_B   = 4'hC;
  localparam logic [3:0] OP_HLT = 4'hF;

  // Branch condition codes
  localparam logic [2:0] CC_NE = 3'b000;
  localparam logic [2:0] CC_EQ = 3'b001;
  localparam logic [2:0] CC_GT = 3'b010;
  localparam logic [2:0] CC_LT = 3'b011;
  localparam logic [2:0] CC_GE = 3'b100;
  localparam logic [2:0] CC_LE = 3'b101;
  localparam logic [2:0] CC_OV = 3'b110;
  localparam logic [2:0] CC_UN = 3'b111;  // Always taken

  localparam logic [3:0] REG_ZERO = 4'd0;  // Hardwired zero register

  // Flag word is {Z, V, N}
  typedef logic [2:0] flags_t;
  localparam int FLAG_Z = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 0;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [3:0] opcode;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [3:0] rt;    // Word offset for LW/SW
    } reg_fmt;
    struct packed {
      logic [3:0] opcode;
      logic [3:0] rd;
      logic [7:0] imm8;
    } imm_fmt;
    struct packed {
      logic [3:0] opcode;
      logic [2:0] ccc;
      logic [8:0] off9;
    } br_fmt;
  } instr_u;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

  // Word memory geometry
  localparam int MEM_AW    = 10;
  localparam int MEM_WORDS = 1024;

  localparam logic [15:0] RESET_PC = 16'h0000;

  // Operand source select for the EX stage
  typedef logic [1:0] fwd_sel_t;
  localparam fwd_sel_t FWD_NONE = 2'd0;  // Register file value from ID/EX
  localparam fwd_sel_t FWD_MEM  = 2'd1;  // EX/MEM result
  localparam fwd_sel_t FWD_WB   = 2'd2;  // Writeback data

endpackage

// File: rtl/unified_memory.sv
`timescale 1ns/100ps

module unified_memory import pipe_pkg::*; (
  input  logic              clk,
  input  logic              load_en,
  input  logic [MEM_AW-1:0] load_addr,
  input  logic [15:0]       load_data,
  input  logic [15:0]       fetch_addr,
  output logic [15:0]       fetch_data,
  input  logic [15:0]       data_addr,
  input  logic [15:0]       data_wdata,
  input  logic              data_we,
  output logic [15:0]       data_rdata
);

  logic [15:0] mem [MEM_WORDS];
  logic [MEM_AW-1:0] fetch_word;
  logic [MEM_AW-1:0] data_word;

  // Byte address to word index
  assign fetch_word = fetch_addr[MEM_AW:1];
  assign data_word  = data_addr[MEM_AW:1];

  assign fetch_data = mem[fetch_word];
  assign data_rdata = mem[data_word];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;   // Program load during reset
    end else if (data_we) begin
      mem[data_word] <= data_wdata;
    end
  end

  // Loading only happens in reset, when no store can be in MEM
  a_no_load_and_store: assert property (@(posedge clk)
    load_en |-> (data_we !== 1'b1));

endmodule

// File: cpu/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  rd_addr1,
  input  logic [3:0]  rd_addr2,
  output logic [15:0] rd_data1,
  output logic [15:0] rd_data2,
  input  logic        wr_en,
  input  logic [3:0]  wr_addr,
  input  logic [15:0] wr_data
);

  logic [15:0] regs [16];
  logic write_live;
  logic hit1;
  logic hit2;

  assign write_live = wr_en && (wr_addr != 4'd0);  // R0 stays zero

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-before-read bypass
  assign hit1 = write_live && (wr_addr == rd_addr1);
  assign hit2 = write_live && (wr_addr == rd_addr2);

  assign rd_data1 = (rd_addr1 == 4'd0) ? 16'h0000 : (hit1 ? wr_data : regs[rd_addr1]);
  assign rd_data2 = (rd_addr2 == 4'd0) ? 16'h0000 : (hit2 ? wr_data : regs[rd_addr2]);

endmodule

// File: cpu/alu.sv
`timescale 1ns/100ps

module alu import isa_pkg::*; (
  input  logic [3:0]  alu_op,
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [15:0] result,
  output flags_t      flags_next
);

  logic [15:0] sum;
  logic [15:0] diff;
  logic add_ovf;
  logic sub_ovf;
  logic ovf;

  assign sum  = a + b;
  assign diff = a - b;

  // Signed overflow, operand signs versus result sign
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

  always_comb begin
    result = a;
    ovf    = 1'b0;
    case (alu_op)
      OP_ADD: begin
        result = sum;    // Also memory address
        ovf    = add_ovf;
      end
      OP_SUB: begin
        result = diff;
        ovf    = sub_ovf;
      end
      OP_XOR: begin
        result = a ^ b;  // V cleared
      end
      OP_LLB: begin
        result = {a[15:8], b[7:0]};
      end
      OP_LHB: begin
        result = {b[7:0], a[7:0]};
      end
      default: begin
        result = a;
      end
    endcase
  end

  always_comb begin
    flags_next         = '0;
    flags_next[FLAG_Z] = (result == 16'h0000);
    flags_next[FLAG_V] = ovf;
    flags_next[FLAG_N] = result[15];
  end

endmodule

// File: cpu/decode_unit.sv
`timescale 1ns/100ps

module decode_unit import isa_pkg::*; (
  input  instr_u      instr,
  input  flags_t      flags,
  input  logic [15:0] pc_plus_2,
  output logic [3:0]  src1,
  output logic [3:0]  src2,
  output logic [3:0]  dst,
  output logic [3:0]  alu_op,
  output logic        use_imm,
  output logic [15:0] imm,
  output logic        mem_read,
  output logic        mem_write,
  output logic        reg_write,
  output logic        sets_flags,
  output logic        is_halt,
  output logic        is_branch,
  output logic        take_branch,
  output logic [15:0] branch_target
);

  logic [3:0] opcode;
  logic bubble;
  logic cond_met;
  logic z;
  logic v;
  logic n;
  logic [15:0] mem_offset;
  logic [15:0] br_offset;

  assign opcode = instr.reg_fmt.opcode;
  assign bubble = (instr == '0);  // All-zero word, no effect

  assign z = flags[FLAG_Z];
  assign v = flags[FLAG_V];
  assign n = flags[FLAG_N];

  assign mem_offset = {{11{instr.reg_fmt.rt[3]}}, instr.reg_fmt.rt, 1'b0};
  assign br_offset  = {{6{instr.br_fmt.off9[8]}}, instr.br_fmt.off9, 1'b0};

  always_comb begin
    src1       = REG_ZERO;
    src2       = REG_ZERO;
    dst        = REG_ZERO;
    alu_op     = opcode;
    use_imm    = 1'b0;
    imm        = mem_offset;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    reg_write  = 1'b0;
    sets_flags = 1'b0;
    is_halt    = 1'b0;
    is_branch  = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_XOR: begin
        src1       = instr.reg_fmt.rs;
        src2       = instr.reg_fmt.rt;
        dst        = instr.reg_fmt.rd;
        reg_write  = ~bubble;
        sets_flags = ~bubble;
      end
      OP_LW: begin
        src1      = instr.reg_fmt.rs;
        dst       = instr.reg_fmt.rd;
        alu_op    = OP_ADD;
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      OP_SW: begin
        src1      = instr.reg_fmt.rs;
        src2      = instr.reg_fmt.rd;  // Store data register
        alu_op    = OP_ADD;
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        src1      = instr.imm_fmt.rd;  // Merge keeps the other byte
        dst       = instr.imm_fmt.rd;
        use_imm   = 1'b1;
        imm       = {8'h00, instr.imm_fmt.imm8};
        reg_write = 1'b1;
      end
      OP_B: begin
        is_branch = 1'b1;
      end
      OP_HLT: begin
        is_halt = 1'b1;
      end
      default: begin
        alu_op = opcode;
      end
    endcase
  end

  // Condition on the current flag register
  always_comb begin
    cond_met = 1'b0;
    case (instr.br_fmt.ccc)
      CC_NE: cond_met = ~z;
      CC_EQ: cond_met = z;
      CC_GT: cond_met = ~z & ~n;
      CC_LT: cond_met = n;
      CC_GE: cond_met = z | ~n;
      CC_LE: cond_met = z | n;
      CC_OV: cond_met = v;
      CC_UN: cond_met = 1'b1;
    endcase
  end

  assign take_branch   = is_branch & cond_met;
  assign branch_target = pc_plus_2 + br_offset;

endmodule

// File: cpu/hazard_forward_unit.sv
`timescale 1ns/100ps

module hazard_forward_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic       clk,
  input  logic [3:0] id_src1,
  input  logic [3:0] id_src2,
  input  logic       id_is_branch,
  input  logic [3:0] ex_src1,
  input  logic [3:0] ex_src2,
  input  logic [3:0] ex_dst,
  input  logic       ex_mem_read,
  input  logic       ex_sets_flags,
  input  logic [3:0] mem_dst,
  input  logic       mem_reg_write,
  input  logic [3:0] wb_dst,
  input  logic       wb_reg_write,
  output fwd_sel_t   fwd_sel_a,
  output fwd_sel_t   fwd_sel_b,
  output logic       stall
);

  logic load_use;
  logic flag_use;

  // Youngest producer wins
  function automatic fwd_sel_t pick_source(
    input logic [3:0] src,
    input logic [3:0] m_dst,
    input logic       m_we,
    input logic [3:0] w_dst,
    input logic       w_we
  );
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (src != REG_ZERO) begin
      if (m_we && (m_dst == src)) begin
        sel = FWD_MEM;
      end else if (w_we && (w_dst == src)) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  assign fwd_sel_a = pick_source(ex_src1, mem_dst, mem_reg_write, wb_dst, wb_reg_write);
  assign fwd_sel_b = pick_source(ex_src2, mem_dst, mem_reg_write, wb_dst, wb_reg_write);

  // Load data is not ready until WB
  assign load_use = ex_mem_read && (ex_dst != REG_ZERO) &&
                    ((ex_dst == id_src1) || (ex_dst == id_src2));

  assign flag_use = id_is_branch && ex_sets_flags;  // Flags land at end of EX

  assign stall = load_use | flag_use;

  // A stall leaves a bubble in EX on the next cycle
  a_stall_bubble: assert property (@(posedge clk)
    stall |=> ((ex_dst == REG_ZERO) && !ex_mem_read && !ex_sets_flags));

endmodule

// File: cpu/cpu.sv
`timescale 1ns/100ps

module cpu import isa_pkg::*, pipe_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              load_en,
  input  logic [MEM_AW-1:0] load_addr,
  input  logic [15:0]       load_data,
  output logic              hlt,
  output logic [15:0]       pc_out
);

  // Fetch
  logic [15:0] pc_q;
  logic [15:0] pc_next;
  logic [15:0] pc_plus_2;
  instr_u      fetch_instr;
  logic        fetch_is_halt;
  logic        branch_redirect;

  // IF/ID and decode
  instr_u      if_id_instr;
  logic [15:0] if_id_pc_plus_2;
  logic [3:0]  id_src1, id_src2, id_dst, id_alu_op;
  logic        id_use_imm, id_mem_read, id_mem_write, id_reg_write;
  logic        id_sets_flags, id_is_halt, id_is_branch, id_take_branch;
  logic [15:0] id_imm, id_branch_target, id_rd_data1, id_rd_data2;

  // ID/EX and execute
  logic [3:0]  ex_src1, ex_src2, ex_dst, ex_alu_op;
  logic        ex_use_imm, ex_mem_read, ex_mem_write, ex_reg_write;
  logic        ex_sets_flags, ex_halt;
  logic [15:0] ex_rd_data1, ex_rd_data2, ex_imm;
  logic [15:0] ex_op_a, ex_op_b_reg, ex_op_b, ex_result;
  flags_t      ex_flags_next;
  flags_t      flags_q;
  fwd_sel_t    fwd_sel_a, fwd_sel_b;
  logic        stall;

  // EX/MEM and MEM/WB
  logic [3:0]  mem_dst, wb_dst;
  logic        mem_load, mem_store, mem_reg_write, mem_halt;
  logic        wb_load, wb_reg_write, wb_halt;
  logic [15:0] mem_result, mem_store_data, mem_rdata;
  logic [15:0] wb_result, wb_rdata, wb_data;
  logic        hlt_q;

  function automatic logic [15:0] fwd_mux(
    input fwd_sel_t    sel,
    input logic [15:0] reg_val,
    input logic [15:0] mem_val,
    input logic [15:0] wb_val
  );
    logic [15:0] val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  unified_memory mem_i (
    .clk        (clk),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (pc_q),
    .fetch_data (fetch_instr),
    .data_addr  ({mem_result[15:1], 1'b0}),
    .data_wdata (mem_store_data),
    .data_we    (mem_store),
    .data_rdata (mem_rdata)
  );

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////

  assign pc_plus_2       = pc_q + 16'd2;
  assign fetch_is_halt   = (fetch_instr.reg_fmt.opcode == OP_HLT);
  assign branch_redirect = id_take_branch & ~stall;  // Stale flags while stalled

  always_comb begin
    if (branch_redirect) begin
      pc_next = id_branch_target;
    end else if (stall || fetch_is_halt) begin
      pc_next = pc_q;     // Hold, HLT freezes here
    end else begin
      pc_next = pc_plus_2;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_out = pc_q;

  always_ff @(posedge clk) begin
    if (rst || branch_redirect) begin
      if_id_instr <= '0;  // Squash wrong-path word
    end else if (!stall) begin
      if_id_instr <= fetch_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_pc_plus_2 <= pc_plus_2;
    end
  end

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  decode_unit decode_i (
    .instr         (if_id_instr),
    .flags         (flags_q),
    .pc_plus_2     (if_id_pc_plus_2),
    .src1          (id_src1),
    .src2          (id_src2),
    .dst           (id_dst),
    .alu_op        (id_alu_op),
    .use_imm       (id_use_imm),
    .imm           (id_imm),
    .mem_read      (id_mem_read),
    .mem_write     (id_mem_write),
    .reg_write     (id_reg_write),
    .sets_flags    (id_sets_flags),
    .is_halt       (id_is_halt),
    .is_branch     (id_is_branch),
    .take_branch   (id_take_branch),
    .branch_target (id_branch_target)
  );

  register_file regs_i (
    .clk      (clk),
    .rst      (rst),
    .rd_addr1 (id_src1),
    .rd_addr2 (id_src2),
    .rd_data1 (id_rd_data1),
    .rd_data2 (id_rd_data2),
    .wr_en    (wb_reg_write),
    .wr_addr  (wb_dst),
    .wr_data  (wb_data)
  );

  hazard_forward_unit hazard_i (
    .clk           (clk),
    .id_src1       (id_src1),
    .id_src2       (id_src2),
    .id_is_branch  (id_is_branch),
    .ex_src1       (ex_src1),
    .ex_src2       (ex_src2),
    .ex_dst        (ex_dst),
    .ex_mem_read   (ex_mem_read),
    .ex_sets_flags (ex_sets_flags),
    .mem_dst       (mem_dst),
    .mem_reg_write (mem_reg_write),
    .wb_dst        (wb_dst),
    .wb_reg_write  (wb_reg_write),
    .fwd_sel_a     (fwd_sel_a),
    .fwd_sel_b     (fwd_sel_b),
    .stall         (stall)
  );

  // Bubble into EX on reset or stall
  always_ff @(posedge clk) begin
    if (rst || stall) begin
      ex_src1       <= REG_ZERO;
      ex_src2       <= REG_ZERO;
      ex_dst        <= REG_ZERO;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_sets_flags <= 1'b0;
      ex_halt       <= 1'b0;
    end else begin
      ex_src1       <= id_src1;
      ex_src2       <= id_src2;
      ex_dst        <= id_dst;
      ex_mem_read   <= id_mem_read;
      ex_mem_write  <= id_mem_write;
      ex_reg_write  <= id_reg_write;
      ex_sets_flags <= id_sets_flags;
      ex_halt       <= id_is_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op   <= id_alu_op;
    ex_use_imm  <= id_use_imm;
    ex_imm      <= id_imm;
    ex_rd_data1 <= id_rd_data1;
    ex_rd_data2 <= id_rd_data2;
  end

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  assign ex_op_a     = fwd_mux(fwd_sel_a, ex_rd_data1, mem_result, wb_data);
  assign ex_op_b_reg = fwd_mux(fwd_sel_b, ex_rd_data2, mem_result, wb_data);  // Also SW data
  assign ex_op_b     = ex_use_imm ? ex_imm : ex_op_b_reg;

  alu alu_i (
    .alu_op     (ex_alu_op),
    .a          (ex_op_a),
    .b          (ex_op_b),
    .result     (ex_result),
    .flags_next (ex_flags_next)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else if (ex_sets_flags) begin
      flags_q <= ex_flags_next;
    end
  end

  //////////////////////////////////////////////////
  // Memory and writeback
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_dst       <= REG_ZERO;
      mem_load      <= 1'b0;
      mem_store     <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_halt      <= 1'b0;
      wb_dst        <= REG_ZERO;
      wb_load       <= 1'b0;
      wb_reg_write  <= 1'b0;
      wb_halt       <= 1'b0;
    end else begin
      mem_dst       <= ex_dst;
      mem_load      <= ex_mem_read;
      mem_store     <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
      mem_halt      <= ex_halt;
      wb_dst        <= mem_dst;
      wb_load       <= mem_load;
      wb_reg_write  <= mem_reg_write;
      wb_halt       <= mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_result     <= ex_result;
    mem_store_data <= ex_op_b_reg;
    wb_result      <= mem_result;
    wb_rdata       <= mem_rdata;
  end

  assign wb_data = wb_load ? wb_rdata : wb_result;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      hlt_q <= 1'b0;
    end else if (wb_halt) begin
      hlt_q <= 1'b1;
    end
  end

  assign hlt = hlt_q;

  a_pc_frozen_in_halt: assert property (@(posedge clk) disable iff (rst)
    hlt |=> $stable(pc_out));

endmodule

// File: test/cpu_programs.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// Word i of prog lands at byte address 2*i

task automatic reg_instr(input logic [3:0] op, input logic [3:0] rd,
                         input logic [3:0] rs, input logic [3:0] rt);
  prog.push_back({op, rd, rs, rt});
endtask

task automatic imm_instr(input logic [3:0] op, input logic [3:0] rd, input logic [7:0] imm8);
  prog.push_back({op, rd, imm8});
endtask

task automatic append_hlt();
  prog.push_back({OP_HLT, 12'h000});
endtask

// Target is a word index, offset counted from the next word
task automatic branch_to(input logic [2:0] ccc, input int target);
  int off;
  off = target - (prog.size() + 1);
  prog.push_back({OP_B, ccc, off[8:0]});
endtask

task automatic set_const(input logic [3:0] rd, input logic [15:0] value);
  imm_instr(OP_LLB, rd, value[7:0]);
  imm_instr(OP_LHB, rd, value[15:8]);
endtask

// Falling through lands on an inline fail halt
task automatic require_taken(input logic [2:0] ccc);
  branch_to(ccc, prog.size() + 2);
  append_hlt();
endtask

// Wrongly taken lands on the halt, the normal path jumps over it
task automatic forbid_taken(input logic [2:0] ccc);
  branch_to(ccc, prog.size() + 2);
  branch_to(CC_UN, prog.size() + 2);
  append_hlt();
endtask

// Bit c of taken set means condition code c must branch
task automatic cond_checks(input logic [7:0] taken);
  for (int c = 0; c < 8; c++) begin
    if (taken[c]) begin
      require_taken(c[2:0]);
    end else begin
      forbid_taken(c[2:0]);
    end
  end
endtask

//////////////////////////////////////////////////
// Test programs
//////////////////////////////////////////////////

task automatic halt_only_prog();
  prog.delete();
  append_hlt();
endtask

task automatic forwarding_prog();
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] s;
  logic [15:0] d;
  logic [15:0] x;
  logic [15:0] e;
  a = 16'h1234;
  b = 16'h0f0f;
  s = a + b;
  d = s - a;
  x = d ^ s;
  e = x + d;
  prog.delete();
  set_const(4'd1, a);
  set_const(4'd2, b);
  reg_instr(OP_ADD, 4'd3, 4'd1, 4'd2);  // r2 from EX/MEM
  reg_instr(OP_SUB, 4'd4, 4'd3, 4'd1);
  reg_instr(OP_XOR, 4'd5, 4'd4, 4'd3);  // r3 from writeback
  reg_instr(OP_ADD, 4'd6, 4'd5, 4'd4);
  set_const(4'd7, e);
  reg_instr(OP_SUB, 4'd0, 4'd6, 4'd7);
  require_taken(CC_EQ);
  append_hlt();
endtask

task automatic store_load_prog();
  prog.delete();
  set_const(4'd1, 16'h0101);            // Odd base, bit 0 dropped
  set_const(4'd2, 16'hbeef);
  reg_instr(OP_SW, 4'd2, 4'd1, 4'd2);   // Byte address 0x0104
  reg_instr(OP_LW, 4'd3, 4'd1, 4'd2);
  reg_instr(OP_SUB, 4'd0, 4'd3, 4'd2);  // Load-use stall
  require_taken(CC_EQ);
  set_const(4'd5, 16'h010a);
  reg_instr(OP_LW, 4'd4, 4'd5, 4'hd);   // Offset -3 words, same location
  reg_instr(OP_SUB, 4'd0, 4'd4, 4'd2);
  require_taken(CC_EQ);
  append_hlt();
endtask

task automatic cond_code_prog();
  prog.delete();
  imm_instr(OP_LLB, 4'd1, 8'd5);
  imm_instr(OP_LLB, 4'd2, 8'd3);
  set_const(4'd3, 16'h7fff);
  reg_instr(OP_SUB, 4'd0, 4'd1, 4'd1);  // Z
  cond_checks(8'b1011_0010);
  reg_instr(OP_SUB, 4'd0, 4'd2, 4'd1);  // N
  cond_checks(8'b1010_1001);
  reg_instr(OP_SUB, 4'd0, 4'd1, 4'd2);  // Positive nonzero
  cond_checks(8'b1001_0101);
  reg_instr(OP_ADD, 4'd0, 4'd3, 4'd3);  // V and N
  cond_checks(8'b1110_1001);
  append_hlt();
endtask

task automatic r0_prog();
  prog.delete();
  imm_instr(OP_LLB, 4'd1, 8'h55);
  reg_instr(OP_ADD, 4'd0, 4'd1, 4'd1);
  imm_instr(OP_LLB, 4'd0, 8'h77);
  imm_instr(OP_LHB, 4'd0, 8'h12);
  reg_instr(OP_ADD, 4'd2, 4'd0, 4'd1);  // R0 must read zero here
  reg_instr(OP_SUB, 4'd0, 4'd2, 4'd1);
  require_taken(CC_EQ);
  reg_instr(OP_SUB, 4'd0, 4'd1, 4'd0);  // Clears Z, branch right behind
  forbid_taken(CC_EQ);
  append_hlt();
endtask

// Ends on the last halt with overflow, on the one before without
task automatic random_add_prog(input logic [15:0] a, input logic [15:0] b,
                               input logic [15:0] sum);
  prog.delete();
  set_const(4'd1, a);
  set_const(4'd2, b);
  set_const(4'd3, sum);
  reg_instr(OP_ADD, 4'd4, 4'd1, 4'd2);
  reg_instr(OP_SUB, 4'd0, 4'd4, 4'd3);
  require_taken(CC_EQ);
  reg_instr(OP_ADD, 4'd4, 4'd1, 4'd2);
  branch_to(CC_OV, prog.size() + 2);
  append_hlt();
  append_hlt();
endtask

`endif

// File: test/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu import isa_pkg::*, pipe_pkg::*;;

  localparam int RESET_CYCLES = 4;
  localparam int HALT_WAIT    = 250;   // Longest program needs about 130
  localparam int MAX_CYCLES   = 2000;

  logic              clk;
  logic              rst;
  logic              load_en;
  logic [MEM_AW-1:0] load_addr;
  logic [15:0]       load_data;
  logic              hlt;
  logic [15:0]       pc_out;

  int     error_count = 0;
  int     cycle_count = 0;
  integer seed = 32'h1c15_117c;

  logic [15:0] prog [$];  // Load queue for the program builders

  `include "cpu_programs.svh"

  cpu dut_i (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .hlt       (hlt),
    .pc_out    (pc_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests finished", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [15:0] last_halt_pc();
    return 2 * (prog.size() - 1);
  endfunction

  //////////////////////////////////////////////////
  // Reset, load and run one program
  //////////////////////////////////////////////////

  task automatic load_and_run(input logic [15:0] exp_pc);
    int waited;
    @(posedge clk);
    rst     <= 1'b1;
    load_en <= 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= i[MEM_AW-1:0];
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    compare_value("hlt", {15'd0, hlt}, 16'd0);  // Still in reset
    compare_value("pc_out", pc_out, RESET_PC);
    @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    @(negedge clk);
    while ((hlt !== 1'b1) && (waited < HALT_WAIT)) begin
      @(negedge clk);
      waited++;
    end
    if (hlt !== 1'b1) begin
      error_count++;
      $display("The core did not halt within %0d cycles, pc_out is %h", HALT_WAIT, pc_out);
    end else begin
      compare_value("pc_out", pc_out, exp_pc);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic halt_at_reset_pc();
    halt_only_prog();
    load_and_run(RESET_PC);
    repeat (4) @(negedge clk);
    compare_value("hlt", {15'd0, hlt}, 16'd1);  // Sticky until reset
    compare_value("pc_out", pc_out, RESET_PC);
  endtask

  task automatic forwarding_chain();
    forwarding_prog();
    load_and_run(last_halt_pc());
  endtask

  task automatic store_then_load();
    store_load_prog();
    load_and_run(last_halt_pc());
  endtask

  task automatic all_condition_codes();
    cond_code_prog();
    load_and_run(last_halt_pc());
  endtask

  task automatic r0_and_flag_stall();
    r0_prog();
    load_and_run(last_halt_pc());
  endtask

  task automatic random_add_overflow();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] sum;
    logic [15:0] exp_pc;
    int          wide;
    logic        ovf;
    for (int round = 0; round < 3; round++) begin
      a = $random(seed);
      b = $random(seed);
      if (round == 2) begin
        a[15:14] = 2'b01;  // Two large positives always overflow
        b[15:14] = 2'b01;
      end
      sum  = a + b;
      wide = $signed(a) + $signed(b);
      ovf  = (wide > 32767) || (wide < -32768);
      random_add_prog(a, b, sum);
      exp_pc = ovf ? last_halt_pc() : last_halt_pc() - 16'd2;
      load_and_run(exp_pc);
    end
  endtask

  initial begin
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    halt_at_reset_pc();
    forwarding_chain();
    store_then_load();
    all_condition_codes();
    r0_and_flag_stall();
    random_add_overflow();
    $display("Tests finished with %0d error(s)", error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+test
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/unified_memory.sv
cpu/register_file.sv
cpu/alu.sv
cpu/decode_unit.sv
cpu/hazard_forward_unit.sv
cpu/cpu.sv
test/tb_cpu.sv
